// File: bus_ctrl.f
hdl/bus_ctrl_pkg.sv
hdl/ctrl_regs.sv
hdl/sfp_port_monitor.sv
hdl/readback_mux.sv
hdl/bus_ctrl.sv
testbench/bus_ctrl_assert.sv
testbench/tb_bus_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Builds the bus_ctrl testbench with Verilator and runs it.
# Exits non-zero when the build fails, the run fails or the log reports failure.

cd "$(dirname "$0")" || exit 1

TOP=tb_bus_ctrl
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module "$TOP" --Mdir obj_dir -f bus_ctrl.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
   echo "Simulation FAILED"
   exit 1
fi
echo "Simulation finished without failures"
exit 0

// File: testbench/tb_bus_ctrl.sv
/*
 * Directed testbench for bus_ctrl. Inputs change 1 ns after a rising edge and
 * outputs are sampled 1 ns after that. Each readback costs one clock cycle.
 */

`timescale 1ns/1ns

module tb_bus_ctrl;

   localparam int          NP        = bus_ctrl_pkg::NUM_SFP_PORTS;
   localparam int          DW        = bus_ctrl_pkg::BUS_DATA_W;
   localparam int          SYNC_WAIT = bus_ctrl_pkg::SYNC_STAGES + 3;
   localparam int          CNT_GAP   = 7;
   localparam logic [31:0] SEED      = 32'h1d2f_b10a;
   localparam logic [7:0]  UNMAPPED  = 8'h05;

   // Cycle budget of each test that the timeout sums
   localparam int RESET_CYCLES = 10;
   localparam int T_RESET_VALS = 1 + NP;
   localparam int T_WRITES     = 2 * 6;
   localparam int T_FIXED      = 6 + CNT_GAP;
   localparam int T_SYNC       = NP * (SYNC_WAIT + 1 + NP);
   localparam int T_LATCH      = NP * (2 * SYNC_WAIT + 6 + 2 * NP);
   localparam int MAX_CYCLES   =
      2 * (T_RESET_VALS + T_WRITES + T_FIXED + T_SYNC + T_LATCH) + RESET_CYCLES;

   logic                                          clk;
   logic                                          i_reset;
   bus_ctrl_pkg::set_bus_t                        i_set;
   bus_ctrl_pkg::rb_req_t                         i_rb;
   logic [bus_ctrl_pkg::CLK_STATUS_W-1:0]         i_clock_status;
   bus_ctrl_pkg::sfp_pins_t [NP-1:0]              i_sfp_pins;
   logic [NP-1:0][bus_ctrl_pkg::PHY_STATUS_W-1:0] i_phy_status;
   logic [DW-1:0]                                 o_rb_data;
   logic [bus_ctrl_pkg::LED_W-1:0]                o_leds;
   logic [bus_ctrl_pkg::SW_RST_W-1:0]             o_sw_rst;
   logic [bus_ctrl_pkg::CLK_CTRL_W-1:0]           o_clock_control;
   logic [NP-1:0][bus_ctrl_pkg::SFP_RS_W-1:0]     o_sfp_rs_drive_low;

   // Expected state from the register map and port rules
   logic [bus_ctrl_pkg::LED_W-1:0]                exp_leds;
   logic [bus_ctrl_pkg::SW_RST_W-1:0]             exp_sw_rst;
   logic [bus_ctrl_pkg::CLK_CTRL_W-1:0]           exp_clock_control;
   logic [NP-1:0][bus_ctrl_pkg::SFP_RS_W-1:0]     exp_rs;
   bus_ctrl_pkg::sfp_pins_t [NP-1:0]              exp_pins;
   bus_ctrl_pkg::sfp_pins_t [NP-1:0]              exp_chg;
   logic [NP-1:0][bus_ctrl_pkg::PHY_STATUS_W-1:0] exp_phy;

   int          errors      = 0;
   int          checks      = 0;
   int unsigned cycle_count = 0;

   bus_ctrl dut (
      .clk                (clk),
      .i_reset            (i_reset),
      .i_set              (i_set),
      .i_rb               (i_rb),
      .i_clock_status     (i_clock_status),
      .i_sfp_pins         (i_sfp_pins),
      .i_phy_status       (i_phy_status),
      .o_rb_data          (o_rb_data),
      .o_leds             (o_leds),
      .o_sw_rst           (o_sw_rst),
      .o_clock_control    (o_clock_control),
      .o_sfp_rs_drive_low (o_sfp_rs_drive_low)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Some tests failed");
         $finish;
      end
   end

   // --------------------------------------------------------------------------
   // Helpers
   // --------------------------------------------------------------------------
   // Lands 1 ns after the next rising edge, where inputs may change
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic compare_word(input string name, input logic [DW-1:0] exp,
                               input logic [DW-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      end
   endtask

   task automatic compare_status(input string name, input bus_ctrl_pkg::sfp_status_t exp,
                                 input bus_ctrl_pkg::sfp_status_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h (flags %b vs %b)",
                  $time, name, exp, act, exp.changed, act.changed);
      end
   endtask

   function automatic logic [7:0] status_addr(input int p);
      return 8'(bus_ctrl_pkg::RB_SFPP_STATUS0) + 8'(p);
   endfunction

   // PHY status, ten zeros, change flags and pins from the top bit down
   function automatic bus_ctrl_pkg::sfp_status_t expected_status(input int p);
      return {exp_phy[p], 10'b0, exp_chg[p], exp_pins[p]};
   endfunction

   task automatic read_word(input logic [7:0] addr, output logic [DW-1:0] data);
      next_cycle();
      i_rb = {1'b0, addr};
      #1;
      data = o_rb_data;
   endtask

   // Strobe for one cycle, then sample the outputs one cycle after the strobe
   task automatic write_setting(input logic [7:0] addr, input logic [DW-1:0] data);
      next_cycle();
      i_set = {1'b1, addr, data};
      next_cycle();
      i_set.stb = 1'b0;
      #1;
   endtask

   task automatic clear_status(input int p);
      next_cycle();
      i_rb = {1'b1, status_addr(p)};
      next_cycle();
      i_rb = '0;
   endtask

   task automatic expect_controls();
      compare_word("o_leds", DW'(exp_leds), DW'(o_leds));
      compare_word("o_sw_rst", DW'(exp_sw_rst), DW'(o_sw_rst));
      compare_word("o_clock_control", DW'(exp_clock_control), DW'(o_clock_control));
      for (int p = 0; p < NP; p++) begin
         compare_word($sformatf("o_sfp_rs_drive_low[%0d]", p), DW'(exp_rs[p]),
                      DW'(o_sfp_rs_drive_low[p]));
      end
   endtask

   task automatic expect_port(input int p);
      logic [DW-1:0] data;
      read_word(status_addr(p), data);
      compare_status($sformatf("o_rb_data (port %0d status)", p), expected_status(p), data);
   endtask

   // --------------------------------------------------------------------------
   // Directed tests
   // --------------------------------------------------------------------------
   task automatic reset_values();
      next_cycle();
      #1;
      expect_controls();
      for (int p = 0; p < NP; p++) expect_port(p);
   endtask

   task automatic settings_writes();
      bus_ctrl_pkg::sr_addr_e sr_list [5];
      logic [DW-1:0]          data;
      sr_list = '{bus_ctrl_pkg::SR_LEDS, bus_ctrl_pkg::SR_SW_RST, bus_ctrl_pkg::SR_CLOCK_CTRL,
                  bus_ctrl_pkg::SR_SFPP_CTRL0, bus_ctrl_pkg::SR_SFPP_CTRL1};
      foreach (sr_list[i]) begin
         data = $urandom;
         write_setting(sr_list[i], data);
         case (sr_list[i])
            bus_ctrl_pkg::SR_LEDS:       exp_leds = data[bus_ctrl_pkg::LED_W-1:0];
            bus_ctrl_pkg::SR_SW_RST:     exp_sw_rst = data[bus_ctrl_pkg::SW_RST_W-1:0];
            bus_ctrl_pkg::SR_CLOCK_CTRL: exp_clock_control = data[bus_ctrl_pkg::CLK_CTRL_W-1:0];
            bus_ctrl_pkg::SR_SFPP_CTRL0: exp_rs[0] = data[bus_ctrl_pkg::SFP_RS_W-1:0];
            default:                     exp_rs[1] = data[bus_ctrl_pkg::SFP_RS_W-1:0];
         endcase
         expect_controls();
      end
      // Unmapped write leaves every output alone
      write_setting(UNMAPPED, $urandom);
      expect_controls();
   endtask

   task automatic fixed_readbacks();
      logic [DW-1:0]                         data;
      logic [DW-1:0]                         first;
      logic [bus_ctrl_pkg::CLK_STATUS_W-1:0] clk_status;
      clk_status = bus_ctrl_pkg::CLK_STATUS_W'($urandom);
      next_cycle();
      i_clock_status = clk_status;
      read_word(bus_ctrl_pkg::RB_CLK_STATUS, data);
      compare_word("o_rb_data (clock status)", DW'(clk_status), data);
      read_word(bus_ctrl_pkg::RB_COMPAT_NUM, data);
      // Major 0x0012 over minor 0x0000
      compare_word("o_rb_data (compat number)", 32'h0012_0000, data);
      read_word(UNMAPPED, data);
      compare_word("o_rb_data (unmapped 0x05)", '0, data);
      read_word(8'hff, data);
      compare_word("o_rb_data (unmapped 0xff)", '0, data);
      read_word(bus_ctrl_pkg::RB_COUNTER, first);
      repeat (CNT_GAP - 1) next_cycle();
      read_word(bus_ctrl_pkg::RB_COUNTER, data);
      compare_word("o_rb_data (counter delta)", DW'(CNT_GAP), data - first);
   endtask

   task automatic status_sync();
      bus_ctrl_pkg::sfp_pins_t                 new_pins;
      logic [bus_ctrl_pkg::PHY_STATUS_W-1:0]   new_phy;
      for (int p = 0; p < NP; p++) begin
         new_pins = 3'($urandom_range(7, 0));
         new_phy  = bus_ctrl_pkg::PHY_STATUS_W'($urandom);
         next_cycle();
         i_sfp_pins[p]   = new_pins;
         i_phy_status[p] = new_phy;
         exp_chg[p]  = exp_chg[p] | (exp_pins[p] ^ new_pins);
         exp_pins[p] = new_pins;
         exp_phy[p]  = new_phy;
         repeat (SYNC_WAIT) next_cycle();
         for (int q = 0; q < NP; q++) expect_port(q);
      end
   endtask

   task automatic change_latch_clear();
      bus_ctrl_pkg::sfp_pins_t mask;
      for (int p = 0; p < NP; p++) begin
         clear_status(p);
         exp_chg[p] = '0;
         expect_port(p);
         // One pin pulses on every port and returns. Port p keeps its flag after
         // the pulse and the other ports hold flags that its clear must not touch
         mask = 3'(3'b001 << $urandom_range(2, 0));
         next_cycle();
         for (int q = 0; q < NP; q++) begin
            i_sfp_pins[q] = exp_pins[q] ^ mask;
         end
         repeat (SYNC_WAIT) next_cycle();
         for (int q = 0; q < NP; q++) begin
            i_sfp_pins[q] = exp_pins[q];
            exp_chg[q]    = exp_chg[q] | mask;
         end
         repeat (SYNC_WAIT) next_cycle();
         for (int q = 0; q < NP; q++) expect_port(q);
         clear_status(p);
         exp_chg[p] = '0;
         for (int q = 0; q < NP; q++) expect_port(q);
      end
   endtask

   initial begin
      void'($urandom(SEED));
      i_reset           = 1'b1;
      i_set             = '0;
      i_rb              = '0;
      i_clock_status    = '0;
      i_sfp_pins        = '0;
      i_phy_status      = '0;
      exp_leds          = '0;
      exp_sw_rst        = '0;
      exp_clock_control = bus_ctrl_pkg::CLK_CTRL_RESET;
      exp_rs            = '0;
      exp_pins          = '0;
      exp_chg           = '0;
      exp_phy           = '0;
      repeat (RESET_CYCLES) next_cycle();
      i_reset = 1'b0;

      reset_values();
      settings_writes();
      fixed_readbacks();
      status_sync();
      change_latch_clear();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: testbench/bus_ctrl_assert.sv
/*
 * Concurrent checks bound into bus_ctrl. Observes the status words and
 * control outputs only and drives nothing.
 */

`timescale 1ns/1ns

module bus_ctrl_assert (
   input logic                                                       clk,
   input logic                                                       i_reset,
   input bus_ctrl_pkg::rb_req_t                                      i_rb,
   input logic [bus_ctrl_pkg::LED_W-1:0]                             o_leds,
   input logic [bus_ctrl_pkg::SW_RST_W-1:0]                          o_sw_rst,
   input logic [bus_ctrl_pkg::CLK_CTRL_W-1:0]                        o_clock_control,
   input logic [bus_ctrl_pkg::NUM_SFP_PORTS-1:0][bus_ctrl_pkg::SFP_RS_W-1:0]
                                                                     o_sfp_rs_drive_low,
   input bus_ctrl_pkg::sfp_status_t [bus_ctrl_pkg::NUM_SFP_PORTS-1:0] sfp_status
);

   // Reset is synchronous, so values show one edge after it is sampled
   a_reset_values: assert property (@(posedge clk)
      i_reset |=> (o_leds == '0 && o_sw_rst == '0 &&
                   o_clock_control == bus_ctrl_pkg::CLK_CTRL_RESET &&
                   o_sfp_rs_drive_low == '0))
      else $error("Control outputs left their reset values while reset was high");

   for (genvar p = 0; p < bus_ctrl_pkg::NUM_SFP_PORTS; p++) begin : g_port
      localparam logic [bus_ctrl_pkg::RB_ADDR_W-1:0] ADDR =
         bus_ctrl_pkg::RB_ADDR_W'(bus_ctrl_pkg::RB_SFPP_STATUS0 + p);

      a_clear_on_read: assert property (@(posedge clk)
         (i_rb.rd_stb && i_rb.addr == ADDR) |=> sfp_status[p].changed == '0)
         else $error("Port %0d change flags still set after a status read", p);
   end

endmodule

bind bus_ctrl bus_ctrl_assert u_assert (
   .clk                (clk),
   .i_reset            (i_reset),
   .i_rb               (i_rb),
   .o_leds             (o_leds),
   .o_sw_rst           (o_sw_rst),
   .o_clock_control    (o_clock_control),
   .o_sfp_rs_drive_low (o_sfp_rs_drive_low),
   .sfp_status         (sfp_status)
);

// File: hdl/bus_ctrl.sv
/*
 * Bus controller register side. Writes are single-cycle strobes, no handshake.
 * Rate-select outputs are drive-low enables; the board tri-states the pad.
 */

`timescale 1ns/1ns

module bus_ctrl (
   input  logic                                    clk,
   input  logic                                    i_reset,
   input  bus_ctrl_pkg::set_bus_t                  i_set,
   input  bus_ctrl_pkg::rb_req_t                   i_rb,
   input  logic [bus_ctrl_pkg::CLK_STATUS_W-1:0]   i_clock_status,
   input  bus_ctrl_pkg::sfp_pins_t [bus_ctrl_pkg::NUM_SFP_PORTS-1:0]
                                                   i_sfp_pins,
   input  logic [bus_ctrl_pkg::NUM_SFP_PORTS-1:0][bus_ctrl_pkg::PHY_STATUS_W-1:0]
                                                   i_phy_status,
   output logic [bus_ctrl_pkg::BUS_DATA_W-1:0]     o_rb_data,
   output logic [bus_ctrl_pkg::LED_W-1:0]          o_leds,
   output logic [bus_ctrl_pkg::SW_RST_W-1:0]       o_sw_rst,
   output logic [bus_ctrl_pkg::CLK_CTRL_W-1:0]     o_clock_control,
   output logic [bus_ctrl_pkg::NUM_SFP_PORTS-1:0][bus_ctrl_pkg::SFP_RS_W-1:0]
                                                   o_sfp_rs_drive_low
);

   logic [bus_ctrl_pkg::NUM_SFP_PORTS-1:0]                    status_clear;
   bus_ctrl_pkg::sfp_status_t [bus_ctrl_pkg::NUM_SFP_PORTS-1:0] sfp_status;

   // ------------------------------------------------------------------------
   // Settings decode
   // ------------------------------------------------------------------------
   ctrl_regs u_ctrl_regs (
      .clk                (clk),
      .i_reset            (i_reset),
      .i_set              (i_set),
      .i_rb               (i_rb),
      .o_leds             (o_leds),
      .o_sw_rst           (o_sw_rst),
      .o_clock_control    (o_clock_control),
      .o_sfp_rs_drive_low (o_sfp_rs_drive_low),
      .o_status_clear     (status_clear)
   );

   // ------------------------------------------------------------------------
   // Per-port monitors
   // ------------------------------------------------------------------------
   for (genvar p = 0; p < bus_ctrl_pkg::NUM_SFP_PORTS; p++) begin : g_port
      sfp_port_monitor u_monitor (
         .clk          (clk),
         .i_reset      (i_reset),
         .i_pins       (i_sfp_pins[p]),
         .i_phy_status (i_phy_status[p]),
         .i_clear      (status_clear[p]),
         .o_status     (sfp_status[p])
      );
   end

   // ------------------------------------------------------------------------
   // Readback
   // ------------------------------------------------------------------------
   // Any 8-bit address is legal here, unmapped ones read zero
   readback_mux u_readback_mux (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_rb_addr      (bus_ctrl_pkg::rb_addr_e'(i_rb.addr)),
      .i_clock_status (i_clock_status),
      .i_sfp_status   (sfp_status),
      .o_rb_data      (o_rb_data)
   );

endmodule

// File: hdl/readback_mux.sv
/*
 * Readback data select, combinational from address to data.
 * Also owns the free-running cycle counter, which wraps at 2^32.
 */

`timescale 1ns/1ns

module readback_mux (
   input  logic                                    clk,
   input  logic                                    i_reset,
   input  bus_ctrl_pkg::rb_addr_e                  i_rb_addr,
   input  logic [bus_ctrl_pkg::CLK_STATUS_W-1:0]   i_clock_status,
   input  bus_ctrl_pkg::sfp_status_t [bus_ctrl_pkg::NUM_SFP_PORTS-1:0]
                                                   i_sfp_status,
   output logic [bus_ctrl_pkg::BUS_DATA_W-1:0]     o_rb_data
);

   logic [bus_ctrl_pkg::BUS_DATA_W-1:0] counter;

   // Free-running counter
   always_ff @(posedge clk) begin
      if (i_reset) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------------------
   always_comb begin
      case (i_rb_addr)
         bus_ctrl_pkg::RB_COUNTER: begin
            o_rb_data = counter;
         end
         bus_ctrl_pkg::RB_CLK_STATUS: begin
            o_rb_data = bus_ctrl_pkg::BUS_DATA_W'(i_clock_status);
         end
         // Major in the upper half
         bus_ctrl_pkg::RB_COMPAT_NUM: begin
            o_rb_data = {bus_ctrl_pkg::COMPAT_MAJOR, bus_ctrl_pkg::COMPAT_MINOR};
         end
         bus_ctrl_pkg::RB_SFPP_STATUS0: begin
            o_rb_data = i_sfp_status[0];
         end
         bus_ctrl_pkg::RB_SFPP_STATUS1: begin
            o_rb_data = i_sfp_status[1];
         end
         default: begin
            o_rb_data = '0;
         end
      endcase
   end

endmodule

// File: hdl/sfp_port_monitor.sv
/*
 * One SFP+ port. Pins and PHY status are asynchronous and go through
 * SYNC_STAGES flops without reset. Change flags stay set until i_clear.
 */

`timescale 1ns/1ns

module sfp_port_monitor (
   input  logic                                    clk,
   input  logic                                    i_reset,
   input  bus_ctrl_pkg::sfp_pins_t                 i_pins,
   input  logic [bus_ctrl_pkg::PHY_STATUS_W-1:0]   i_phy_status,
   input  logic                                    i_clear,
   output bus_ctrl_pkg::sfp_status_t               o_status
);

   localparam int LAST = bus_ctrl_pkg::SYNC_STAGES - 1;

   // Stage 0 samples the pad, stage LAST is safe to use
   bus_ctrl_pkg::sfp_pins_t [LAST:0]                          pin_sync;
   logic [LAST:0][bus_ctrl_pkg::PHY_STATUS_W-1:0]             phy_sync;

   // Previous synchronized pin sample, for edge detection
   bus_ctrl_pkg::sfp_pins_t                                   pin_prev;
   bus_ctrl_pkg::sfp_pins_t                                   pin_changed;
   bus_ctrl_pkg::sfp_pins_t                                   chgd;

   // ------------------------------------------------------------------------
   // Synchronizers
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      pin_sync[0] <= i_pins;
      phy_sync[0] <= i_phy_status;
      for (int s = 1; s <= LAST; s++) begin
         pin_sync[s] <= pin_sync[s-1];
         phy_sync[s] <= phy_sync[s-1];
      end
      pin_prev <= pin_sync[LAST];
   end

   // ------------------------------------------------------------------------
   // Sticky change flags
   // ------------------------------------------------------------------------
   assign pin_changed = pin_sync[LAST] ^ pin_prev;

   // A clear in the same cycle as a new change wins
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         chgd <= '0;
      end else begin
         chgd <= chgd | pin_changed;
      end
   end

   always_comb begin
      o_status.phy_status = phy_sync[LAST];
      o_status.reserved   = '0;
      o_status.changed    = chgd;
      o_status.pins       = pin_sync[LAST];
   end

endmodule

// File: hdl/ctrl_regs.sv
/*
 * Settings bus decoder. Writes land at the strobe edge and show one cycle later.
 * Status read strobes become combinational per-port clear pulses.
 */

`timescale 1ns/1ns

module ctrl_regs (
   input  logic                                  clk,
   input  logic                                  i_reset,
   input  bus_ctrl_pkg::set_bus_t                i_set,
   input  bus_ctrl_pkg::rb_req_t                 i_rb,
   output logic [bus_ctrl_pkg::LED_W-1:0]        o_leds,
   output logic [bus_ctrl_pkg::SW_RST_W-1:0]     o_sw_rst,
   output logic [bus_ctrl_pkg::CLK_CTRL_W-1:0]   o_clock_control,
   output logic [bus_ctrl_pkg::NUM_SFP_PORTS-1:0][bus_ctrl_pkg::SFP_RS_W-1:0]
                                                 o_sfp_rs_drive_low,
   output logic [bus_ctrl_pkg::NUM_SFP_PORTS-1:0] o_status_clear
);

   // ------------------------------------------------------------------------
   // Control registers
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_leds             <= '0;
         o_sw_rst           <= '0;
         o_clock_control    <= bus_ctrl_pkg::CLK_CTRL_RESET;
         o_sfp_rs_drive_low <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            bus_ctrl_pkg::SR_LEDS: begin
               o_leds <= i_set.data[bus_ctrl_pkg::LED_W-1:0];
            end
            bus_ctrl_pkg::SR_SW_RST: begin
               o_sw_rst <= i_set.data[bus_ctrl_pkg::SW_RST_W-1:0];
            end
            bus_ctrl_pkg::SR_CLOCK_CTRL: begin
               o_clock_control <= i_set.data[bus_ctrl_pkg::CLK_CTRL_W-1:0];
            end
            // Bit 0 drives RS0 low, bit 1 drives RS1 low
            bus_ctrl_pkg::SR_SFPP_CTRL0: begin
               o_sfp_rs_drive_low[0] <= i_set.data[bus_ctrl_pkg::SFP_RS_W-1:0];
            end
            bus_ctrl_pkg::SR_SFPP_CTRL1: begin
               o_sfp_rs_drive_low[1] <= i_set.data[bus_ctrl_pkg::SFP_RS_W-1:0];
            end
            default: begin
               // Unmapped write, nothing changes
            end
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Clear-on-read pulses
   // ------------------------------------------------------------------------
   // Port p owns readback address RB_SFPP_STATUS0 + p
   always_comb begin
      for (int p = 0; p < bus_ctrl_pkg::NUM_SFP_PORTS; p++) begin
         o_status_clear[p] = i_rb.rd_stb &&
            (i_rb.addr == bus_ctrl_pkg::RB_ADDR_W'(bus_ctrl_pkg::RB_SFPP_STATUS0 + p));
      end
   end

endmodule

// File: hdl/bus_ctrl_pkg.sv
/*
 * Register map, widths and shared types of the bus controller.
 * Settings and readback share one 32-bit data width. Rate-select pads are open drain.
 */

package bus_ctrl_pkg;

   // ------------------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------------------
   localparam int SET_ADDR_W    = 8;
   localparam int RB_ADDR_W     = 8;
   localparam int BUS_DATA_W    = 32;

   localparam int LED_W         = 8;
   localparam int SW_RST_W      = 4;
   localparam int CLK_CTRL_W    = 7;
   localparam int CLK_STATUS_W  = 8;
   localparam int SFP_RS_W      = 2;
   localparam int PHY_STATUS_W  = 16;

   localparam int NUM_SFP_PORTS = 2;

   // Flops per synchronizer chain
   localparam int SYNC_STAGES   = 2;

   // ------------------------------------------------------------------------
   // Reset values and fixed readback words
   // ------------------------------------------------------------------------
   // Bit 6 enables the GPS-disciplined oscillator
   localparam logic [CLK_CTRL_W-1:0] CLK_CTRL_RESET = 7'b100_0000;

   localparam logic [15:0] COMPAT_MAJOR = 16'h0012;
   localparam logic [15:0] COMPAT_MINOR = 16'h0000;

   // ------------------------------------------------------------------------
   // Address maps
   // ------------------------------------------------------------------------
   // Software reset bits: [0] PHY, [1] radio clock domain,
   // [2] radio clock PLL, [3] ADC IDELAYCTRL
   typedef enum logic [SET_ADDR_W-1:0] {
      SR_LEDS       = 8'd0,
      SR_SW_RST     = 8'd1,
      SR_CLOCK_CTRL = 8'd2,
      SR_SFPP_CTRL0 = 8'd8,
      SR_SFPP_CTRL1 = 8'd9
   } sr_addr_e;

   // Addresses not listed read back as zero
   typedef enum logic [RB_ADDR_W-1:0] {
      RB_COUNTER      = 8'd0,
      RB_CLK_STATUS   = 8'd3,
      RB_COMPAT_NUM   = 8'd6,
      RB_SFPP_STATUS0 = 8'd8,
      RB_SFPP_STATUS1 = 8'd9
   } rb_addr_e;

   // ------------------------------------------------------------------------
   // Bus and status structs
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [BUS_DATA_W-1:0] data;
   } set_bus_t;

   typedef struct packed {
      logic                 rd_stb;
      logic [RB_ADDR_W-1:0] addr;
   } rb_req_t;

   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfp_pins_t;

   // One port's readback word, 32 bits
   typedef struct packed {
      logic [PHY_STATUS_W-1:0] phy_status;
      logic [9:0]              reserved;
      sfp_pins_t               changed;
      sfp_pins_t               pins;
   } sfp_status_t;

endpackage
